/* sim.f */
hdl/icachePkg.sv
hdl/dataSram.sv
hdl/tagArray.sv
hdl/refillBuffer.sv
hdl/icacheCtrl.sv
hdl/icacheTop.sv
dv/memModel.sv
dv/icacheTb.sv

/* run.sh */
#!/usr/bin/env bash
# build and run the icache testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f sim.f --top-module icacheTb -Mdir obj_dir
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

./obj_dir/VicacheTb > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "TESTS FAILED" sim.log; then
    exit 1
fi
exit 0

/* dv/icacheTb.sv */
`timescale 1ns/1ps

module icacheTb;

    localparam int PERIOD = 100;
    localparam int CYCLES_PER_ENTRY = 40;

    typedef struct packed {
        logic [31:0] addr;
        logic        refill;
        logic [7:0]  len;
        logic        chain;
    } stimEntry_t;

    logic        clk;
    logic        rst_n;
    logic        valid_i;
    logic [31:0] addr_i;
    logic        addrOk_o;
    logic        dataOk_o;
    logic [63:0] rdData_o;
    logic        rdValid_o;
    logic        rdReady_i;
    logic [31:0] rdAddr_o;
    logic [7:0]  rdLen_o;
    logic        beatValid_i;
    logic [63:0] beatData_i;
    logic        beatLast_i;
    int          reqCount;
    int          burstErrors;
    stimEntry_t  stimTable[$];
    logic        tableLoaded;
    logic [7:0]  seenLen;
    logic [31:0] seenAddr;
    int          checkErrors;
    int          entriesFailed;

    icacheTop #(.uncachedRegion(4'h3)) icacheTop_inst (
        .clk(clk), .rst_n(rst_n), .valid_i(valid_i), .addr_i(addr_i),
        .addrOk_o(addrOk_o), .dataOk_o(dataOk_o), .rdData_o(rdData_o),
        .rdValid_o(rdValid_o), .rdReady_i(rdReady_i), .rdAddr_o(rdAddr_o),
        .rdLen_o(rdLen_o), .beatValid_i(beatValid_i), .beatData_i(beatData_i),
        .beatLast_i(beatLast_i)
    );

    memModel #(.seed(32'h20907ca2)) memModel_inst (
        .clk(clk), .rst_n(rst_n), .rdValid_i(rdValid_o), .rdAddr_i(rdAddr_o),
        .rdLen_i(rdLen_o), .rdReady_o(rdReady_i), .beatValid_o(beatValid_i),
        .beatData_o(beatData_i), .beatLast_o(beatLast_i), .reqCount_o(reqCount),
        .burstErrors_o(burstErrors)
    );

    initial clk = 1'b0;
    always #(PERIOD / 2) clk = ~clk;

    // expected fetch word, from the aligned word address
    function automatic logic [63:0] expectWord(input logic [31:0] addr);
        logic [31:0] wordAddr;
        wordAddr = {addr[31:3], 3'b000};
        return {wordAddr, ~wordAddr};
    endfunction

    task automatic addEntry(input logic [31:0] addr, input logic refill, input logic [7:0] len,
                            input logic chain);
        stimEntry_t e;
        e.addr = addr;
        e.refill = refill;
        e.len = len;
        e.chain = chain;
        stimTable.push_back(e);
    endtask

    // length and address of the last memory request
    always @(negedge clk) begin
        if (rdValid_o) begin
            seenLen <= rdLen_o;
            seenAddr <= rdAddr_o;
        end
    end

    initial begin
        wait (tableLoaded);
        repeat (5 + stimTable.size() * CYCLES_PER_ENTRY) @(posedge clk);
        $display("watchdog expired, the run did not finish in time");
        $display("TESTS FAILED");
        $finish;
    end

    initial begin
        int          i;
        int          latency;
        int          reqBefore;
        int          entryErrors;
        logic        nextChained;
        logic [31:0] expAddr;
        stimEntry_t  cur;
        valid_i = 1'b0;
        addr_i = '0;
        rst_n = 1'b0;
        checkErrors = 0;
        entriesFailed = 0;
        tableLoaded = 1'b0;
        // set 2 fill and hits, the first chained after the refill
        addEntry(32'h0000_1040, 1'b1, 8'd3, 1'b0);
        addEntry(32'h0000_1048, 1'b0, 8'd0, 1'b1);
        addEntry(32'h0000_1050, 1'b0, 8'd0, 1'b1);
        addEntry(32'h0000_1058, 1'b0, 8'd0, 1'b1);
        addEntry(32'h0000_1040, 1'b0, 8'd0, 1'b0);
        // miss on the last word of a line goes to way 1
        addEntry(32'h0000_2078, 1'b1, 8'd3, 1'b0);
        addEntry(32'h0000_2060, 1'b0, 8'd0, 1'b1);
        // set 5 lines P, Q and R
        addEntry(32'h0000_40a0, 1'b1, 8'd3, 1'b0);
        addEntry(32'h0000_80a8, 1'b1, 8'd3, 1'b0);
        addEntry(32'h0000_40b8, 1'b0, 8'd0, 1'b0);
        addEntry(32'h0000_80a0, 1'b0, 8'd0, 1'b1);
        addEntry(32'h0000_c0b0, 1'b1, 8'd3, 1'b0);
        addEntry(32'h0000_80b0, 1'b0, 8'd0, 1'b0);
        addEntry(32'h0000_40a8, 1'b1, 8'd3, 1'b0);
        addEntry(32'h0000_c0b8, 1'b0, 8'd0, 1'b0);
        // uncached region 3, same index as the set 2 line
        addEntry(32'h3000_1048, 1'b1, 8'd0, 1'b0);
        addEntry(32'h3000_1048, 1'b1, 8'd0, 1'b0);
        addEntry(32'h3000_1044, 1'b1, 8'd0, 1'b1);
        addEntry(32'h0000_1050, 1'b0, 8'd0, 1'b0);
        // toggle must be untouched by the uncached reads
        addEntry(32'h0001_00a0, 1'b1, 8'd3, 1'b0);
        addEntry(32'h0000_40b0, 1'b0, 8'd0, 1'b0);
        addEntry(32'h0000_c0a0, 1'b1, 8'd3, 1'b0);
        addEntry(32'h0001_00b8, 1'b0, 8'd0, 1'b1);
        tableLoaded = 1'b1;

        repeat (5) @(posedge clk);
        rst_n <= 1'b1;
        @(negedge clk);
        if (addrOk_o !== 1'b1) begin
            $display("Mismatch addrOk_o after reset: expected %h, got %h", 1'b1, addrOk_o);
            checkErrors++;
        end
        if (dataOk_o !== 1'b0 || rdValid_o !== 1'b0) begin
            $display("Mismatch dataOk_o/rdValid_o after reset: expected 0, got %h/%h",
                     dataOk_o, rdValid_o);
            checkErrors++;
        end
        $display("reset state: %s", checkErrors == 0 ? "ok" : "error");

        for (i = 0; i < stimTable.size(); i++) begin
            cur = stimTable[i];
            entryErrors = 0;
            if (!cur.chain) begin
                @(posedge clk);
                valid_i <= 1'b1;
                addr_i <= cur.addr;
                @(negedge clk);
                while (!addrOk_o) begin
                    @(negedge clk);
                end
            end
            // accepted at the coming edge
            reqBefore = reqCount;
            @(posedge clk);
            nextChained = 1'b0;
            if (i + 1 < stimTable.size()) begin
                nextChained = stimTable[i + 1].chain;
            end
            if (nextChained) begin
                addr_i <= stimTable[i + 1].addr;
            end else begin
                valid_i <= 1'b0;
            end
            @(negedge clk);
            latency = 1;
            while (!dataOk_o) begin
                @(negedge clk);
                latency++;
            end

            if (rdData_o !== expectWord(cur.addr)) begin
                $display("Mismatch rdData_o entry %0d addr %h: expected %h, got %h",
                         i, cur.addr, expectWord(cur.addr), rdData_o);
                entryErrors++;
            end
            if (cur.refill && reqCount - reqBefore != 1) begin
                $display("entry %0d expected one memory request but saw %0d",
                         i, reqCount - reqBefore);
                entryErrors++;
            end
            if (!cur.refill && reqCount != reqBefore) begin
                $display("entry %0d should hit but made a memory request", i);
                entryErrors++;
            end
            if (!cur.refill && latency != 1) begin
                $display("entry %0d hit data came %0d cycles after accept, not 1", i, latency);
                entryErrors++;
            end
            if (cur.refill) begin
                expAddr = cur.len == 8'd0 ? cur.addr : {cur.addr[31:5], 5'b00000};
                if (seenLen !== cur.len) begin
                    $display("Mismatch rdLen_o entry %0d: expected %h, got %h",
                             i, cur.len, seenLen);
                    entryErrors++;
                end
                if (seenAddr !== expAddr) begin
                    $display("Mismatch rdAddr_o entry %0d: expected %h, got %h",
                             i, expAddr, seenAddr);
                    entryErrors++;
                end
            end
            checkErrors += entryErrors;
            if (entryErrors != 0) begin
                entriesFailed++;
            end
            $display("entry %0d addr %h %s: %s", i, cur.addr, cur.refill ? "refill" : "hit",
                     entryErrors == 0 ? "ok" : "error");
        end

        repeat (2) @(posedge clk);
        $display("summary: %0d entries, %0d failed, %0d check errors, %0d memory errors",
                 stimTable.size(), entriesFailed, checkErrors, burstErrors);
        if (checkErrors == 0 && burstErrors == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

/* dv/memModel.sv */
`timescale 1ns/1ps

module memModel #(
    parameter logic [31:0] seed = 32'h1
) (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        rdValid_i,
    input  logic [31:0] rdAddr_i,
    input  logic [7:0]  rdLen_i,
    output logic        rdReady_o,
    output logic        beatValid_o,
    output logic [63:0] beatData_o,
    output logic        beatLast_o,
    output int          reqCount_o,
    output int          burstErrors_o
);

    // each beat is its own word address followed by the inverse of it
    function automatic logic [63:0] beatWord(input logic [31:0] wordAddr);
        return {wordAddr, ~wordAddr};
    endfunction

    initial begin
        int          delay;
        int          beatIdx;
        logic [31:0] baseAddr;
        logic [7:0]  len;
        void'($urandom(seed));
        rdReady_o = 1'b0;
        beatValid_o = 1'b0;
        beatData_o = '0;
        beatLast_o = 1'b0;
        reqCount_o = 0;
        burstErrors_o = 0;
        wait (rst_n);
        forever begin
            // ready drops for 0 to 3 cycles before each offer
            delay = $urandom % 4;
            repeat (delay) begin
                @(posedge clk);
                rdReady_o <= 1'b0;
            end
            @(posedge clk);
            rdReady_o <= 1'b1;
            @(negedge clk);
            if (rdValid_i) begin
                baseAddr = {rdAddr_i[31:3], 3'b000};
                len = rdLen_i;
                reqCount_o++;
                // ready stays up through the burst so a stray request shows
                @(posedge clk);
                beatIdx = 0;
                while (beatIdx <= int'(len)) begin
                    if ($urandom % 3 == 0) begin
                        beatValid_o <= 1'b0;
                        beatLast_o <= 1'b0;
                    end else begin
                        beatValid_o <= 1'b1;
                        beatData_o <= beatWord(baseAddr + 32'(8 * beatIdx));
                        beatLast_o <= beatIdx == int'(len);
                        beatIdx++;
                    end
                    @(negedge clk);
                    if (rdValid_i) begin
                        $display("memory model got a new read request during an active burst");
                        burstErrors_o++;
                    end
                    @(posedge clk);
                end
                beatValid_o <= 1'b0;
                beatLast_o <= 1'b0;
            end
        end
    end

endmodule

/* hdl/icacheTop.sv */
`timescale 1ns/1ps

module icacheTop #(
    parameter logic [3:0] uncachedRegion = 4'h3
) (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          valid_i,
    input  logic [icachePkg::ADDR_W-1:0]  addr_i,
    output logic                          addrOk_o,
    output logic                          dataOk_o,
    output logic [icachePkg::XLEN-1:0]    rdData_o,
    output logic                          rdValid_o,
    input  logic                          rdReady_i,
    output logic [icachePkg::ADDR_W-1:0]  rdAddr_o,
    output logic [7:0]                    rdLen_o,
    input  logic                          beatValid_i,
    input  logic [icachePkg::XLEN-1:0]    beatData_i,
    input  logic                          beatLast_i
);

    import icachePkg::*;

    localparam int HALF_W = XLEN * LINE_BEATS / 2;

    logic                       fillEn;
    logic [XLEN*LINE_BEATS-1:0] lineData;
    logic                       lineDone;
    fetchAddr_t                 lookupAddr;
    logic                       allocEn;
    logic                       way0Hit;
    logic                       way1Hit;
    logic                       victimWay;
    logic [INDEX_W-1:0]         sramIndex;
    logic                       wenWay0;
    logic                       wenWay1;
    logic [HALF_W-1:0]          sramRdata0;
    logic [HALF_W-1:0]          sramRdata1;
    logic [HALF_W-1:0]          sramRdata2;
    logic [HALF_W-1:0]          sramRdata3;

    icacheCtrl #(
        .uncachedRegion(uncachedRegion)
    ) icacheCtrl_inst (
        .clk(clk), .rst_n(rst_n), .valid_i(valid_i), .addr_i(addr_i),
        .addrOk_o(addrOk_o), .dataOk_o(dataOk_o), .rdData_o(rdData_o),
        .rdValid_o(rdValid_o), .rdReady_i(rdReady_i), .rdAddr_o(rdAddr_o),
        .rdLen_o(rdLen_o), .fillEn(fillEn), .lineData(lineData), .lineDone(lineDone),
        .lookupAddr(lookupAddr), .allocEn(allocEn), .way0Hit(way0Hit),
        .way1Hit(way1Hit), .victimWay(victimWay), .sramIndex(sramIndex),
        .wenWay0(wenWay0), .wenWay1(wenWay1), .sramRdata0(sramRdata0),
        .sramRdata1(sramRdata1), .sramRdata2(sramRdata2), .sramRdata3(sramRdata3)
    );

    tagArray tagArray_inst (
        .clk(clk), .rst_n(rst_n), .lookupAddr(lookupAddr), .allocEn(allocEn),
        .way0Hit(way0Hit), .way1Hit(way1Hit), .victimWay(victimWay)
    );

    refillBuffer refillBuffer_inst (
        .clk(clk), .rst_n(rst_n), .fillEn(fillEn), .beatValid_i(beatValid_i),
        .beatData_i(beatData_i), .beatLast_i(beatLast_i),
        .lineData(lineData), .lineDone(lineDone)
    );

    // each way is a low and a high 128-bit half of the line
    dataSram #(.depth(1 << INDEX_W), .width(HALF_W)) sramWay0Lo_inst (
        .clk(clk), .index(sramIndex), .wen(wenWay0),
        .wdata(lineData[HALF_W-1:0]), .rdata(sramRdata0)
    );
    dataSram #(.depth(1 << INDEX_W), .width(HALF_W)) sramWay0Hi_inst (
        .clk(clk), .index(sramIndex), .wen(wenWay0),
        .wdata(lineData[2*HALF_W-1:HALF_W]), .rdata(sramRdata1)
    );
    dataSram #(.depth(1 << INDEX_W), .width(HALF_W)) sramWay1Lo_inst (
        .clk(clk), .index(sramIndex), .wen(wenWay1),
        .wdata(lineData[HALF_W-1:0]), .rdata(sramRdata2)
    );
    dataSram #(.depth(1 << INDEX_W), .width(HALF_W)) sramWay1Hi_inst (
        .clk(clk), .index(sramIndex), .wen(wenWay1),
        .wdata(lineData[2*HALF_W-1:HALF_W]), .rdata(sramRdata3)
    );

endmodule

/* hdl/icacheCtrl.sv */
`timescale 1ns/1ps

module icacheCtrl #(
    parameter logic [3:0] uncachedRegion = 4'h3
) (
    input  logic                                              clk,
    input  logic                                              rst_n,
    input  logic                                              valid_i,
    input  icachePkg::fetchAddr_t                             addr_i,
    output logic                                              addrOk_o,
    output logic                                              dataOk_o,
    output logic [icachePkg::XLEN-1:0]                        rdData_o,
    output logic                                              rdValid_o,
    input  logic                                              rdReady_i,
    output logic [icachePkg::ADDR_W-1:0]                      rdAddr_o,
    output logic [7:0]                                        rdLen_o,
    output logic                                              fillEn,
    input  logic [icachePkg::XLEN*icachePkg::LINE_BEATS-1:0]  lineData,
    input  logic                                              lineDone,
    output icachePkg::fetchAddr_t                             lookupAddr,
    output logic                                              allocEn,
    input  logic                                              way0Hit,
    input  logic                                              way1Hit,
    input  logic                                              victimWay,
    output logic [icachePkg::INDEX_W-1:0]                     sramIndex,
    output logic                                              wenWay0,
    output logic                                              wenWay1,
    input  logic [127:0]                                      sramRdata0,
    input  logic [127:0]                                      sramRdata1,
    input  logic [127:0]                                      sramRdata2,
    input  logic [127:0]                                      sramRdata3
);

    import icachePkg::*;

    cacheState_t state;
    cacheState_t nextState;
    fetchAddr_t  reqLatch;

    logic                         uncached;
    logic                         cacheHit;
    logic                         serve;
    logic                         accept;
    logic                         bypass;
    logic                         uncachedDone;
    logic                         fillWay;
    logic [1:0]                   wordSel;
    logic [XLEN*LINE_BEATS-1:0]   way0Line;
    logic [XLEN*LINE_BEATS-1:0]   way1Line;

    // region view of the latched word picks the uncached window
    assign uncached = reqLatch.regionView.region == uncachedRegion;
    assign cacheHit = (way0Hit || way1Hit) && !uncached;

    // word is ready from the SRAM, the refill buffer or the single uncached beat
    assign serve = (state == compare) && (cacheHit || bypass || uncachedDone);
    assign addrOk_o = (state == idle) || serve;
    assign dataOk_o = serve;
    assign accept = valid_i && addrOk_o;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= idle;
        end else begin
            state <= nextState;
        end
    end

    always_comb begin
        nextState = state;
        case (state)
            idle: begin
                if (accept) begin
                    nextState = compare;
                end
            end
            compare: begin
                if (!serve) begin
                    nextState = missWait;
                end else if (!accept) begin
                    nextState = idle;
                end
            end
            missWait: begin
                if (rdReady_i) begin
                    nextState = fill;
                end
            end
            fill: begin
                if (lineDone) begin
                    nextState = uncached ? compare : replace;
                end
            end
            replace: begin
                nextState = compare;
            end
            default: begin
                nextState = idle;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            reqLatch <= addr_i;
        end
    end

    // one-cycle flags for serving from the buffer, plus the way being filled
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            bypass <= 1'b0;
            uncachedDone <= 1'b0;
            fillWay <= 1'b0;
        end else begin
            bypass <= state == replace;
            uncachedDone <= (state == fill) && lineDone && uncached;
            if (allocEn) begin
                fillWay <= victimWay;
            end
        end
    end

    assign fillEn = state == fill;
    assign allocEn = (state == fill) && lineDone && !uncached;
    assign lookupAddr = reqLatch;
    assign wenWay0 = (state == replace) && !fillWay;
    assign wenWay1 = (state == replace) && fillWay;

    // incoming index while accepting so a hit reads at the accepting edge
    assign sramIndex = accept ? addr_i.cacheView.index : reqLatch.cacheView.index;

    assign rdValid_o = (state == missWait) && rdReady_i;
    assign rdLen_o = uncached ? 8'd0 : 8'(LINE_BEATS - 1);
    assign rdAddr_o = uncached ? reqLatch
                               : {reqLatch.cacheView.tag, reqLatch.cacheView.index,
                                  {OFFSET_W{1'b0}}};

    assign way0Line = {sramRdata1, sramRdata0};
    assign way1Line = {sramRdata3, sramRdata2};
    assign wordSel = reqLatch.cacheView.offset[OFFSET_W-1:3];

    always_comb begin
        if (uncachedDone) begin
            rdData_o = lineData[XLEN-1:0];
        end else if (bypass) begin
            // SRAM still holds the old line during the write cycle
            rdData_o = lineData[wordSel*XLEN +: XLEN];
        end else if (way1Hit) begin
            rdData_o = way1Line[wordSel*XLEN +: XLEN];
        end else begin
            rdData_o = way0Line[wordSel*XLEN +: XLEN];
        end
    end

    // memory read only from missWait, for a request the tags did not hold
    assert property (@(posedge clk) disable iff (!rst_n)
        rdValid_o |-> (state == missWait) && !cacheHit)
        else $error("rdValid_o outside missWait or for a cached line");

    // the written way is the one the tag array just allocated
    assert property (@(posedge clk) disable iff (!rst_n)
        (wenWay0 || wenWay1) |-> !(wenWay0 && wenWay1) && (wenWay0 ? way0Hit : way1Hit))
        else $error("SRAM write does not match the allocated way");

    // a served word comes from a fresh request or a finished refill
    assert property (@(posedge clk) disable iff (!rst_n)
        dataOk_o |-> (state == compare) && ($past(accept) || bypass || uncachedDone))
        else $error("dataOk_o without a request or refill");

endmodule

/* hdl/refillBuffer.sv */
`timescale 1ns/1ps

module refillBuffer (
    input  logic                                              clk,
    input  logic                                              rst_n,
    input  logic                                              fillEn,
    input  logic                                              beatValid_i,
    input  logic [icachePkg::XLEN-1:0]                        beatData_i,
    input  logic                                              beatLast_i,
    output logic [icachePkg::XLEN*icachePkg::LINE_BEATS-1:0]  lineData,
    output logic                                              lineDone
);

    import icachePkg::*;

    logic [$clog2(LINE_BEATS)-1:0] beatCnt;
    logic                          beatTake;

    assign beatTake = fillEn && beatValid_i;
    assign lineDone = beatTake && beatLast_i;

    // counter restarts on the last beat, so an uncached beat lands in slot 0
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            beatCnt <= '0;
        end else if (beatTake) begin
            if (beatLast_i) begin
                beatCnt <= '0;
            end else begin
                beatCnt <= beatCnt + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (beatTake) begin
            lineData[beatCnt*XLEN +: XLEN] <= beatData_i;
        end
    end

    assert property (@(posedge clk) disable iff (!rst_n)
        beatLast_i |-> beatValid_i)
        else $error("beatLast_i without beatValid_i");

endmodule

/* hdl/tagArray.sv */
`timescale 1ns/1ps

module tagArray (
    input  logic                  clk,
    input  logic                  rst_n,
    input  icachePkg::fetchAddr_t lookupAddr,
    input  logic                  allocEn,
    output logic                  way0Hit,
    output logic                  way1Hit,
    output logic                  victimWay
);

    import icachePkg::*;

    localparam int SETS = 1 << INDEX_W;

    logic [TAG_W-1:0]   tagWay0 [SETS];
    logic [TAG_W-1:0]   tagWay1 [SETS];
    logic [SETS-1:0]    validWay0;
    logic [SETS-1:0]    validWay1;
    logic               toggle;
    logic [INDEX_W-1:0] setIdx;
    logic [TAG_W-1:0]   reqTag;

    assign setIdx = lookupAddr.cacheView.index;
    assign reqTag = lookupAddr.cacheView.tag;

    // tags hold no reset, valid bits gate them
    always_ff @(posedge clk) begin
        if (allocEn) begin
            if (toggle) begin
                tagWay1[setIdx] <= reqTag;
            end else begin
                tagWay0[setIdx] <= reqTag;
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            validWay0 <= '0;
            validWay1 <= '0;
            toggle <= 1'b0;
        end else if (allocEn) begin
            if (toggle) begin
                validWay1[setIdx] <= 1'b1;
            end else begin
                validWay0[setIdx] <= 1'b1;
            end
            // victim alternates on every line fill
            toggle <= ~toggle;
        end
    end

    assign way0Hit = validWay0[setIdx] && (tagWay0[setIdx] == reqTag);
    assign way1Hit = validWay1[setIdx] && (tagWay1[setIdx] == reqTag);
    assign victimWay = toggle;

    // a line is only ever allocated into one way
    assert property (@(posedge clk) disable iff (!rst_n)
        !(way0Hit && way1Hit))
        else $error("same line present in both ways");

endmodule

/* hdl/dataSram.sv */
`timescale 1ns/1ps

module dataSram #(
    parameter int depth = 64,
    parameter int width = 128
) (
    input  logic                     clk,
    input  logic [$clog2(depth)-1:0] index,
    input  logic                     wen,
    input  logic [width-1:0]         wdata,
    output logic [width-1:0]         rdata
);

    logic [width-1:0] mem [depth];

    // single port, read returns the old contents during a write
    always_ff @(posedge clk) begin
        if (wen) begin
            mem[index] <= wdata;
        end
        rdata <= mem[index];
    end

endmodule

/* hdl/icachePkg.sv */
package icachePkg;

    // fetch word and address widths
    localparam int XLEN = 64;
    localparam int ADDR_W = 32;

    // one line is four 64-bit beats
    localparam int LINE_BEATS = 4;

    // address split for 64 sets of 32-byte lines
    localparam int TAG_W = 21;
    localparam int INDEX_W = 6;
    localparam int OFFSET_W = 5;

    typedef enum logic [2:0] {
        idle,
        compare,
        missWait,
        fill,
        replace
    } cacheState_t;

    // same fetch address, seen as cache fields or as a memory region
    typedef union packed {
        struct packed {
            logic [TAG_W-1:0]    tag;
            logic [INDEX_W-1:0]  index;
            logic [OFFSET_W-1:0] offset;
        } cacheView;
        struct packed {
            logic [3:0]        region;
            logic [ADDR_W-5:0] rest;
        } regionView;
    } fetchAddr_t;

endpackage
